// ==== hw/conv_defines.svh ====
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// taps per kernel
`define CONV_KSIZE 4

// activations streamed in per chunk
`define CONV_ROW_LEN 8

// valid outputs per chunk
`define CONV_OUT_LEN (`CONV_ROW_LEN - `CONV_KSIZE + 1)

// requant shift amount width
`define CONV_SHIFT_W 4

`endif

// ==== hw/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

  typedef logic signed [7:0]  data_t;      // int8 weight, activation or result
  typedef logic signed [31:0] acc_t;
  typedef logic [7:0]         chunk_cnt_t;

  typedef enum logic [2:0] {
    ld_idle,
    ld_weights,
    ld_inputs,
    ld_wait,   // load done, waiting for the bank to free up
    ld_fin
  } ld_state_t;

  typedef enum logic [1:0] {
    com_idle,
    com_wait,
    com_run,
    com_fin
  } com_state_t;

  // str_fin is the store of the last chunk
  typedef enum logic [1:0] {
    str_idle,
    str_wait,
    str_run,
    str_fin
  } str_state_t;

endpackage

`default_nettype wire

// ==== hw/conv_controller.sv ====
`default_nettype none

module conv_controller (
  input  logic                 clk,
  input  logic                 glb_rst,
  input  logic                 soft_rst,
  input  logic                 conv_start,
  input  conv_pkg::chunk_cnt_t n_chunks,
  input  logic                 w_load_fin,
  input  logic                 x_load_fin,
  input  logic                 compute_fin,
  input  logic                 store_fin,
  input  logic                 y_done,
  output logic                 w_load,
  output logic                 x_load,
  output logic                 compute,
  output logic                 store,
  output logic                 load_bank,
  output logic                 compute_bank,
  output logic                 store_bank,
  output logic                 last_chunk_store,
  output logic                 conv_busy,
  output logic                 conv_fin
);
  import conv_pkg::*;

  ld_state_t  ld_state;
  com_state_t com_state;
  str_state_t str_state;
  chunk_cnt_t nl;   // loads completed
  chunk_cnt_t nc;   // computes completed
  chunk_cnt_t ns;   // stores completed
  logic       start_ok;
  logic       ld_go;
  logic       com_go;
  logic       str_go;
  logic       drained;

  ////////////////////////////////////////
  // scheduling conditions

  assign start_ok = conv_start && (ld_state == ld_idle) && (n_chunks != '0);

  // bank nl[0] is free once compute nl-2 is done
  assign ld_go = start_ok || ((ld_state == ld_wait) && (nc >= nl - 8'd1));

  assign com_go = (com_state == com_wait) && (nl > nc)
               && ((nc == '0) || (ns >= nc - 8'd1));   // result bank free

  assign str_go = (str_state == str_wait) && (nc > ns);

  assign conv_fin = (str_state == str_fin) && store_fin && drained;

  assign load_bank        = nl[0];
  assign compute_bank     = nc[0];
  assign store_bank       = ns[0];
  assign last_chunk_store = (str_state == str_fin);
  assign conv_busy        = (ld_state != ld_idle);

  ////////////////////////////////////////
  // load machine

  always_ff @(posedge clk or negedge glb_rst) begin
    if (!glb_rst) begin
      ld_state <= ld_idle;
      nl       <= '0;
    end else if (soft_rst) begin
      ld_state <= ld_idle;
      nl       <= '0;
    end else begin
      case (ld_state)
        ld_idle: begin
          if (start_ok) begin
            ld_state <= ld_weights;
            nl       <= '0;
          end
        end
        ld_weights: if (w_load_fin) ld_state <= ld_inputs;
        ld_inputs: begin
          if (x_load_fin) begin
            nl       <= nl + 8'd1;
            ld_state <= (nl + 8'd1 == n_chunks) ? ld_fin : ld_wait;
          end
        end
        ld_wait: if (ld_go) ld_state <= ld_weights;
        ld_fin:  if (conv_fin) ld_state <= ld_idle;
        default: ld_state <= ld_idle;
      endcase
    end
  end

  ////////////////////////////////////////
  // compute machine

  always_ff @(posedge clk or negedge glb_rst) begin
    if (!glb_rst) begin
      com_state <= com_idle;
      nc        <= '0;
    end else if (soft_rst) begin
      com_state <= com_idle;
      nc        <= '0;
    end else begin
      case (com_state)
        com_idle: begin
          if (start_ok) begin
            com_state <= com_wait;
            nc        <= '0;
          end
        end
        com_wait: if (com_go) com_state <= com_run;
        com_run: begin
          if (compute_fin) begin
            nc        <= nc + 8'd1;
            com_state <= (nc + 8'd1 == n_chunks) ? com_fin : com_wait;
          end
        end
        com_fin: if (conv_fin) com_state <= com_idle;
        default: com_state <= com_idle;
      endcase
    end
  end

  ////////////////////////////////////////
  // store machine

  always_ff @(posedge clk or negedge glb_rst) begin
    if (!glb_rst) begin
      str_state <= str_idle;
      ns        <= '0;
    end else if (soft_rst) begin
      str_state <= str_idle;
      ns        <= '0;
    end else begin
      case (str_state)
        str_idle: begin
          if (start_ok) begin
            str_state <= str_wait;
            ns        <= '0;
          end
        end
        str_wait: begin
          if (str_go) str_state <= (ns == n_chunks - 8'd1) ? str_fin : str_run;
        end
        str_run: begin
          if (store_fin) begin
            ns        <= ns + 8'd1;
            str_state <= str_wait;
          end
        end
        str_fin: if (conv_fin) str_state <= str_idle;
        default: str_state <= str_idle;
      endcase
    end
  end

  // last word has left through y
  always_ff @(posedge clk or negedge glb_rst) begin
    if (!glb_rst) begin
      drained <= 1'b0;
    end else if (soft_rst || start_ok) begin
      drained <= 1'b0;
    end else if (y_done) begin
      drained <= 1'b1;
    end
  end

  // start pulses, one cycle behind their condition
  always_ff @(posedge clk or negedge glb_rst) begin
    if (!glb_rst) begin
      w_load  <= 1'b0;
      x_load  <= 1'b0;
      compute <= 1'b0;
      store   <= 1'b0;
    end else if (soft_rst) begin
      w_load  <= 1'b0;
      x_load  <= 1'b0;
      compute <= 1'b0;
      store   <= 1'b0;
    end else begin
      w_load  <= ld_go;
      x_load  <= (ld_state == ld_weights) && w_load_fin;
      compute <= com_go;
      store   <= str_go;
    end
  end

endmodule

`default_nettype wire

// ==== hw/operand_loader.sv ====
`default_nettype none

module operand_loader #(
  parameter int DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       glb_rst,
  input  logic                       soft_rst,
  input  logic                       load,
  input  logic                       bank,
  input  conv_pkg::data_t            in_data,
  input  logic                       in_valid,
  input  logic                       rd_bank,
  input  logic [$clog2(DEPTH)-1:0]   rd_addr,
  output logic                       in_ready,
  output logic                       load_fin,
  output conv_pkg::data_t            rd_data
);
  import conv_pkg::*;

  localparam int AW = $clog2(DEPTH);

  data_t          buf_mem [2][DEPTH];
  logic           wr_bank;
  logic [AW-1:0]  wr_ptr;
  logic           xfer;

  assign xfer    = in_valid && in_ready;
  assign rd_data = buf_mem[rd_bank][rd_addr];   // engine reads without latency

  always_ff @(posedge clk or negedge glb_rst) begin
    if (!glb_rst) begin
      in_ready <= 1'b0;
      load_fin <= 1'b0;
      wr_bank  <= 1'b0;
      wr_ptr   <= '0;
    end else if (soft_rst) begin
      in_ready <= 1'b0;
      load_fin <= 1'b0;
      wr_bank  <= 1'b0;
      wr_ptr   <= '0;
    end else begin
      load_fin <= 1'b0;
      if (load) begin
        in_ready <= 1'b1;
        wr_bank  <= bank;
        wr_ptr   <= '0;
      end else if (xfer) begin
        wr_ptr <= wr_ptr + 1'b1;
        if (wr_ptr == AW'(DEPTH - 1)) begin   // last word of the bank
          in_ready <= 1'b0;
          load_fin <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) buf_mem[wr_bank][wr_ptr] <= in_data;
  end

endmodule

`default_nettype wire

// ==== hw/conv_engine.sv ====
`default_nettype none
`include "conv_defines.svh"

module conv_engine (
  input  logic                              clk,
  input  logic                              glb_rst,
  input  logic                              soft_rst,
  input  logic                              compute,
  input  logic                              bank,
  input  logic [`CONV_SHIFT_W-1:0]          quan_shift,
  input  conv_pkg::data_t                   w_rd_data,
  input  conv_pkg::data_t                   x_rd_data,
  output logic [$clog2(`CONV_KSIZE)-1:0]    w_rd_addr,
  output logic [$clog2(`CONV_ROW_LEN)-1:0]  x_rd_addr,
  output logic                              rd_bank,
  output logic                              res_we,
  output logic                              res_bank,
  output logic [$clog2(`CONV_OUT_LEN)-1:0]  res_addr,
  output conv_pkg::data_t                   res_data,
  output logic                              compute_fin
);
  import conv_pkg::*;

  localparam int KW = $clog2(`CONV_KSIZE);
  localparam int XW = $clog2(`CONV_ROW_LEN);
  localparam int OW = $clog2(`CONV_OUT_LEN);

  logic          busy;
  logic          cur_bank;
  logic [KW-1:0] tap_idx;
  logic [OW-1:0] out_idx;
  logic          last_tap;
  logic          last_out;
  acc_t          acc;
  acc_t          prod;
  acc_t          acc_nxt;
  acc_t          shifted;
  data_t         sat;

  assign w_rd_addr = tap_idx;
  assign x_rd_addr = XW'(out_idx) + XW'(tap_idx);
  assign rd_bank   = cur_bank;
  assign res_bank  = cur_bank;   // chunk k results go to bank k mod 2 too

  assign last_tap = (tap_idx == KW'(`CONV_KSIZE - 1));
  assign last_out = (out_idx == OW'(`CONV_OUT_LEN - 1));

  ////////////////////////////////////////
  // mac and requant

  assign prod    = acc_t'(w_rd_data) * acc_t'(x_rd_data);
  assign acc_nxt = (tap_idx == '0) ? prod : acc + prod;
  assign shifted = acc_nxt >>> quan_shift;   // truncates toward -inf

  always_comb begin
    if (shifted > 32'sd127) begin
      sat = 8'sd127;
    end else if (shifted < -32'sd128) begin
      sat = -8'sd128;
    end else begin
      sat = data_t'(shifted);
    end
  end

  ////////////////////////////////////////
  // output / tap sequencing

  always_ff @(posedge clk or negedge glb_rst) begin
    if (!glb_rst) begin
      busy        <= 1'b0;
      cur_bank    <= 1'b0;
      tap_idx     <= '0;
      out_idx     <= '0;
      res_we      <= 1'b0;
      compute_fin <= 1'b0;
    end else if (soft_rst) begin
      busy        <= 1'b0;
      cur_bank    <= 1'b0;
      tap_idx     <= '0;
      out_idx     <= '0;
      res_we      <= 1'b0;
      compute_fin <= 1'b0;
    end else begin
      res_we      <= busy && last_tap;
      compute_fin <= busy && last_tap && last_out;
      if (compute) begin
        busy     <= 1'b1;
        cur_bank <= bank;
        tap_idx  <= '0;
        out_idx  <= '0;
      end else if (busy) begin
        tap_idx <= tap_idx + 1'b1;
        if (last_tap) begin
          tap_idx <= '0;
          out_idx <= out_idx + 1'b1;
          if (last_out) busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (busy) acc <= acc_nxt;
    if (busy && last_tap) begin
      res_data <= sat;
      res_addr <= out_idx;
    end
  end

endmodule

`default_nettype wire

// ==== hw/result_store.sv ====
`default_nettype none
`include "conv_defines.svh"

module result_store (
  input  logic                              clk,
  input  logic                              glb_rst,
  input  logic                              soft_rst,
  input  logic                              res_we,
  input  logic                              res_bank,
  input  logic [$clog2(`CONV_OUT_LEN)-1:0]  res_addr,
  input  conv_pkg::data_t                   res_data,
  input  logic                              store,
  input  logic                              bank,
  input  logic                              last_chunk_store,
  input  logic                              y_ready,
  output conv_pkg::data_t                   y_data,
  output logic                              y_valid,
  output logic                              y_last,
  output logic                              store_fin
);
  import conv_pkg::*;

  localparam int OW = $clog2(`CONV_OUT_LEN);

  data_t         res_mem [2][`CONV_OUT_LEN];
  logic          rd_bank;
  logic [OW-1:0] rd_ptr;
  logic          last_word;

  assign last_word = (rd_ptr == OW'(`CONV_OUT_LEN - 1));
  assign y_data    = res_mem[rd_bank][rd_ptr];
  assign y_last    = y_valid && last_chunk_store && last_word;

  always_ff @(posedge clk or negedge glb_rst) begin
    if (!glb_rst) begin
      y_valid   <= 1'b0;
      store_fin <= 1'b0;
      rd_bank   <= 1'b0;
      rd_ptr    <= '0;
    end else if (soft_rst) begin
      y_valid   <= 1'b0;
      store_fin <= 1'b0;
      rd_bank   <= 1'b0;
      rd_ptr    <= '0;
    end else begin
      store_fin <= 1'b0;
      if (store) begin
        y_valid <= 1'b1;
        rd_bank <= bank;
        rd_ptr  <= '0;
      end else if (y_valid && y_ready) begin
        if (last_word) begin
          y_valid   <= 1'b0;
          store_fin <= 1'b1;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (res_we) res_mem[res_bank][res_addr] <= res_data;
  end

endmodule

`default_nettype wire

// ==== hw/conv_accel_top.sv ====
`default_nettype none
`include "conv_defines.svh"

module conv_accel_top (
  input  logic                      clk,
  input  logic                      glb_rst,
  input  logic                      soft_rst,
  input  logic                      conv_start,
  input  conv_pkg::chunk_cnt_t      n_chunks,
  input  logic [`CONV_SHIFT_W-1:0]  quan_shift,
  input  conv_pkg::data_t           w_data,
  input  logic                      w_valid,
  output logic                      w_ready,
  input  conv_pkg::data_t           x_data,
  input  logic                      x_valid,
  output logic                      x_ready,
  output conv_pkg::data_t           y_data,
  output logic                      y_valid,
  input  logic                      y_ready,
  output logic                      y_last,
  output logic                      conv_busy,
  output logic                      conv_fin
);
  import conv_pkg::*;

  logic w_load, x_load, compute, store;
  logic w_load_fin, x_load_fin, compute_fin, store_fin;
  logic load_bank, compute_bank, store_bank;
  logic last_chunk_store;
  logic y_done;

  // engine side of the operand buffers
  logic                              rd_bank;
  logic [$clog2(`CONV_KSIZE)-1:0]    w_rd_addr;
  logic [$clog2(`CONV_ROW_LEN)-1:0]  x_rd_addr;
  data_t                             w_rd_data;
  data_t                             x_rd_data;

  // engine to result buffer
  logic                              res_we;
  logic                              res_bank;
  logic [$clog2(`CONV_OUT_LEN)-1:0]  res_addr;
  data_t                             res_data;

  assign y_done = y_valid & y_ready & y_last;   // final word of the run

  conv_controller conv_controller_inst (
    .clk, .glb_rst, .soft_rst, .conv_start, .n_chunks,
    .w_load_fin, .x_load_fin, .compute_fin, .store_fin, .y_done,
    .w_load, .x_load, .compute, .store,
    .load_bank, .compute_bank, .store_bank,
    .last_chunk_store, .conv_busy, .conv_fin
  );

  operand_loader #(.DEPTH(`CONV_KSIZE)) weight_loader_inst (
    .clk, .glb_rst, .soft_rst,
    .load(w_load), .bank(load_bank),
    .in_data(w_data), .in_valid(w_valid), .in_ready(w_ready),
    .load_fin(w_load_fin),
    .rd_bank, .rd_addr(w_rd_addr), .rd_data(w_rd_data)
  );

  operand_loader #(.DEPTH(`CONV_ROW_LEN)) input_loader_inst (
    .clk, .glb_rst, .soft_rst,
    .load(x_load), .bank(load_bank),
    .in_data(x_data), .in_valid(x_valid), .in_ready(x_ready),
    .load_fin(x_load_fin),
    .rd_bank, .rd_addr(x_rd_addr), .rd_data(x_rd_data)
  );

  conv_engine conv_engine_inst (
    .clk, .glb_rst, .soft_rst,
    .compute, .bank(compute_bank), .quan_shift,
    .w_rd_data, .x_rd_data, .w_rd_addr, .x_rd_addr, .rd_bank,
    .res_we, .res_bank, .res_addr, .res_data, .compute_fin
  );

  result_store result_store_inst (
    .clk, .glb_rst, .soft_rst,
    .res_we, .res_bank, .res_addr, .res_data,
    .store, .bank(store_bank), .last_chunk_store,
    .y_ready, .y_data, .y_valid, .y_last, .store_fin
  );

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // 8 ns period
  end

endmodule

`default_nettype wire

// ==== verification/conv_accel_checker.sv ====
`default_nettype none

module conv_accel_checker (
  input logic            clk,
  input logic            glb_rst,
  input logic            soft_rst,
  input logic            w_ready,
  input logic            x_ready,
  input conv_pkg::data_t y_data,
  input logic            y_valid,
  input logic            y_ready,
  input logic            conv_fin
);
  timeunit 1ns;
  timeprecision 100ps;

  // a stalled result word holds until it is taken
  y_stall_hold: assert property (
    @(posedge clk) disable iff (!glb_rst)
    (y_valid && !y_ready && !soft_rst) |=> (y_valid && $stable(y_data))
  ) else $error("y stream changed while stalled");

  conv_fin_single: assert property (
    @(posedge clk) disable iff (!glb_rst)
    conv_fin |=> !conv_fin
  ) else $error("conv_fin high on two consecutive cycles");

  ready_low_in_reset: assert property (
    @(posedge clk) !glb_rst |-> (!w_ready && !x_ready)
  ) else $error("ready output high during reset");

endmodule

`default_nettype wire

// ==== verification/conv_accel_tb.sv ====
`default_nettype none
`include "conv_defines.svh"

module conv_accel_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import conv_pkg::*;

  logic                     clk;
  logic                     glb_rst;
  logic                     soft_rst;
  logic                     conv_start;
  chunk_cnt_t               n_chunks;
  logic [`CONV_SHIFT_W-1:0] quan_shift;
  data_t                    w_data;
  logic                     w_valid;
  logic                     w_ready;
  data_t                    x_data;
  logic                     x_valid;
  logic                     x_ready;
  data_t                    y_data;
  logic                     y_valid;
  logic                     y_ready;
  logic                     y_last;
  logic                     conv_busy;
  logic                     conv_fin;

  data_t       w_q [$];
  data_t       x_q [$];
  data_t       exp_q [$];
  bit          w_go_q [$];   // valid gap pattern
  bit          x_go_q [$];
  bit          rdy_q [$];    // y_ready back-pressure
  bit          w_go;
  bit          x_go;
  data_t       exp_y;
  data_t       wk [`CONV_KSIZE];
  data_t       xk [`CONV_ROW_LEN];
  logic [31:0] lfsr = 32'h1cf516d0;
  int          errors;
  int          checked;
  int          fin_cnt;
  logic        fin_due;
  logic        busy_due;

  tb_clock_gen clk_gen_inst (.clk);

  conv_accel_top conv_accel_top_inst (
    .clk, .glb_rst, .soft_rst, .conv_start, .n_chunks, .quan_shift,
    .w_data, .w_valid, .w_ready, .x_data, .x_valid, .x_ready,
    .y_data, .y_valid, .y_ready, .y_last, .conv_busy, .conv_fin
  );

  bind conv_accel_top conv_accel_checker conv_accel_checker_inst (
    .clk, .glb_rst, .soft_rst, .w_ready, .x_ready,
    .y_data, .y_valid, .y_ready, .conv_fin
  );

  ////////////////////////////////////////
  // random source and reference model

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // valid convolution, arithmetic shift, int8 saturation
  function automatic int ref_out(input int j, input int sh);
    int acc;
    int k;
    acc = 0;
    for (k = 0; k < `CONV_KSIZE; k++) begin
      acc += int'(wk[k]) * int'(xk[j + k]);
    end
    acc = acc >>> sh;
    if (acc > 127) return 127;
    if (acc < -128) return -128;
    return acc;
  endfunction

  task automatic check_val(input string name, input logic signed [31:0] got, input int exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns %s: got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic abort_run(input string why);
    errors++;
    $display("timeout at %0t ns: %s", $time, why);
    $display("%0d errors, %0d results compared", errors, checked);
    $display("Simulation failed");
    $finish;
  endtask

  ////////////////////////////////////////
  // run control

  task automatic make_chunk(input int sh, input bit big);
    int k;
    int i;
    int j;
    for (k = 0; k < `CONV_KSIZE; k++) begin
      if (big) wk[k] = rand_bits(1) ? data_t'(127) : data_t'(-128);
      else wk[k] = data_t'(rand_bits(8));
      w_q.push_back(wk[k]);
    end
    for (i = 0; i < `CONV_ROW_LEN; i++) begin
      xk[i] = data_t'(rand_bits(8));
      x_q.push_back(xk[i]);
    end
    for (j = 0; j < `CONV_OUT_LEN; j++) begin
      exp_q.push_back(data_t'(ref_out(j, sh)));
    end
  endtask

  task automatic start_run(input int n, input int sh, input bit big, input bit gaps,
                           input bit bp);
    int c;
    int i;
    for (c = 0; c < n; c++) begin
      make_chunk(sh, big);
      for (i = 0; i < 16; i++) begin
        w_go_q.push_back(!gaps || (rand_bits(2) != 0));
        x_go_q.push_back(!gaps || (rand_bits(2) != 0));
      end
      for (i = 0; i < 10; i++) begin
        rdy_q.push_back(!bp || rand_bits(1));
      end
    end
    @(posedge clk);
    n_chunks   <= chunk_cnt_t'(n);
    quan_shift <= 4'(sh);
    conv_start <= 1'b1;
    @(posedge clk);
    conv_start <= 1'b0;
  endtask

  task automatic wait_fin(input int limit);
    int n;
    n = 0;
    while (conv_fin !== 1'b1) begin
      @(posedge clk);
      n++;
      if (n > limit) abort_run("no conv_fin from the DUT");
    end
  endtask

  task automatic wait_results(input int target, input int limit);
    int n;
    n = 0;
    while (checked < target) begin
      @(posedge clk);
      n++;
      if (n > limit) abort_run("results stopped coming out");
    end
  endtask

  task automatic finish_run(input int limit);
    wait_fin(limit);
    repeat (2) @(posedge clk);
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected results never came out", exp_q.size());
    end
    if (w_q.size() != 0 || x_q.size() != 0) begin
      errors++;
      $display("operands left over that the DUT never took");
    end
    check_val("conv_fin pulse count", fin_cnt, 1);
    exp_q.delete();
    fin_cnt = 0;
  endtask

  ////////////////////////////////////////
  // stream sources and result sink

  always @(posedge clk) begin
    if (soft_rst) begin
      w_q.delete();
      w_go_q.delete();
      w_valid <= 1'b0;
    end else if (!w_valid || w_ready) begin
      if (w_valid) void'(w_q.pop_front());   // word just transferred
      w_go = (w_go_q.size() > 0) ? w_go_q.pop_front() : 1'b1;
      w_valid <= w_go && (w_q.size() > 0);
      if (w_q.size() > 0) w_data <= w_q[0];
    end
  end

  always @(posedge clk) begin
    if (soft_rst) begin
      x_q.delete();
      x_go_q.delete();
      x_valid <= 1'b0;
    end else if (!x_valid || x_ready) begin
      if (x_valid) void'(x_q.pop_front());
      x_go = (x_go_q.size() > 0) ? x_go_q.pop_front() : 1'b1;
      x_valid <= x_go && (x_q.size() > 0);
      if (x_q.size() > 0) x_data <= x_q[0];
    end
  end

  always @(posedge clk) begin
    if (soft_rst) begin
      rdy_q.delete();
      y_ready <= 1'b1;
    end else if (y_valid) begin
      y_ready <= (rdy_q.size() > 0) ? rdy_q.pop_front() : 1'b1;
    end
  end

  // compare
  always @(posedge clk) begin
    if (!glb_rst || soft_rst) begin
      exp_q.delete();
      fin_due  = 1'b0;
      busy_due = 1'b0;
    end else begin
      check_val("conv_fin", conv_fin, fin_due);
      if (busy_due) check_val("conv_busy", conv_busy, 0);
      if (conv_fin) fin_cnt++;
      busy_due = conv_fin;
      fin_due  = 1'b0;
      if (y_valid && y_ready) begin
        checked++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("extra result word %0d came out at %0t ns", y_data, $time);
        end else begin
          exp_y = exp_q.pop_front();
          check_val("y_data", y_data, exp_y);
          check_val("y_last", y_last, exp_q.size() == 0);
          fin_due = (exp_q.size() == 0);   // last word of the run
        end
      end
    end
  end

  ////////////////////////////////////////
  // main sequence

  initial begin
    glb_rst    = 1'b0;
    soft_rst   = 1'b0;
    conv_start = 1'b0;
    n_chunks   = '0;
    quan_shift = '0;
    w_data     = '0;
    w_valid    = 1'b0;
    x_data     = '0;
    x_valid    = 1'b0;
    y_ready    = 1'b1;
    errors     = 0;
    checked    = 0;
    fin_cnt    = 0;
    repeat (4) @(posedge clk);
    glb_rst <= 1'b1;
    repeat (2) @(posedge clk);

    start_run(1, rand_bits(4), 1'b0, 1'b0, 1'b0);   // single chunk
    finish_run(200);

    // six chunks with gaps, and a start while busy
    start_run(6, rand_bits(4), 1'b0, 1'b1, 1'b0);
    repeat (40) @(posedge clk);
    check_val("conv_busy", conv_busy, 1);
    conv_start <= 1'b1;
    @(posedge clk);
    conv_start <= 1'b0;
    finish_run(2000);

    start_run(5, rand_bits(4), 1'b0, 1'b1, 1'b1);   // back-pressure
    finish_run(3000);

    // saturation, then shift truncation
    start_run(2, 0, 1'b1, 1'b0, 1'b0);
    finish_run(1000);
    start_run(2, 15, 1'b1, 1'b1, 1'b1);
    finish_run(1000);

    // soft reset in mid-run, then a fresh run
    start_run(4, rand_bits(4), 1'b0, 1'b1, 1'b1);
    wait_results(checked + 7, 2000);
    soft_rst <= 1'b1;
    @(posedge clk);
    soft_rst <= 1'b0;
    @(posedge clk);
    check_val("conv_busy", conv_busy, 0);
    check_val("w_ready", w_ready, 0);
    check_val("x_ready", x_ready, 0);
    check_val("y_valid", y_valid, 0);
    fin_cnt = 0;
    repeat (2) @(posedge clk);
    start_run(3, rand_bits(4), 1'b0, 1'b1, 1'b1);
    finish_run(3000);

    $display("%0d errors, %0d results compared", errors, checked);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hw
hw/conv_pkg.sv
hw/conv_controller.sv
hw/operand_loader.sv
hw/conv_engine.sv
hw/result_store.sv
hw/conv_accel_top.sv
verification/tb_clock_gen.sv
verification/conv_accel_checker.sv
verification/conv_accel_tb.sv
